/* Makefile */
VERILATOR  := verilator
FLAGS      := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing
TOP        := tb_dma_request_unit
FILELIST   := compile.f
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := Errors found
PASS_MSG   := No errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended without a result"; exit 1; fi
	@echo "Simulation passed"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* compile.f */
hw/pcxt_dma_pkg.sv
hw/dreq_if.sv
hw/dreq_edge_detect.sv
hw/dreq_channel.sv
hw/dma_priority_arbiter.sv
hw/dma_request_unit.sv
tb/dma_request_unit_asserts.sv
tb/tb_dma_request_unit.sv

/* hw/dma_priority_arbiter.sv */
module dma_priority_arbiter
(
    input  logic                        clock,
    input  logic                        reset,
    dreq_if.arbiter                     chan [pcxt_dma_pkg::num_channels],
    output logic                        grant_valid,
    output pcxt_dma_pkg::dma_channel_t  grant_channel,
    input  logic                        grant_ready
);

    import pcxt_dma_pkg::*;

    arb_state_t     state;
    dma_lines_t     pending_vec;
    dma_lines_t     ack_q;
    dma_lines_t     eligible;
    dma_channel_t   pick;
    logic           pick_valid;
    logic           transfer;

    generate
        for (genvar i = 0; i < num_channels; i++)
        begin : g_collect
            assign pending_vec[i]     = chan[i].pending;
            assign chan[i].acknowledge = ack_q[i];
        end
    endgenerate

    // A channel still being acknowledged has not cleared its latch yet
    assign eligible = pending_vec & ~ack_q;

    // Lowest channel wins, so scan downward and keep the last hit
    always_comb
    begin
        pick       = '0;
        pick_valid = 1'b0;
        for (int i = num_channels - 1; i >= 0; i--)
        begin
            if (eligible[i])
            begin
                pick       = dma_channel_t'(i);
                pick_valid = 1'b1;
            end
        end
    end

    assign grant_valid = (state == arb_offer);
    assign transfer    = grant_valid & grant_ready;

    // Offer is held unchanged until accepted
    always_ff @(posedge clock, posedge reset)
    begin
        if (reset)
        begin
            state         <= arb_idle;
            grant_channel <= '0;
        end
        else
        begin
            case (state)
                arb_idle:
                begin
                    if (pick_valid)
                    begin
                        grant_channel <= pick;
                        state         <= arb_offer;
                    end
                end
                arb_offer:
                begin
                    if (transfer)
                    begin
                        state <= arb_idle;
                    end
                end
                default:
                begin
                    state <= arb_idle;
                end
            endcase
        end
    end

    // One-cycle acknowledge for the accepted channel
    always_ff @(posedge clock, posedge reset)
    begin
        if (reset)
        begin
            ack_q <= '0;
        end
        else if (transfer)
        begin
            ack_q <= dma_lines_t'(1) << grant_channel;
        end
        else
        begin
            ack_q <= '0;
        end
    end

endmodule

/* hw/dma_request_unit.sv */
module dma_request_unit
(
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        refresh_timer,
    input  pcxt_dma_pkg::dma_ext_t      dma_request,
    input  pcxt_dma_pkg::dma_lines_t    dma_mask,
    output logic                        grant_valid,
    output pcxt_dma_pkg::dma_channel_t  grant_channel,
    input  logic                        grant_ready,
    output pcxt_dma_pkg::dma_lines_t    dma_acknowledge_n
);

    import pcxt_dma_pkg::*;

    // One link per channel between edge detect, latch and arbiter
    dreq_if chan [num_channels] ();

    dreq_edge_detect edge_detect_inst
    (
        .clock          (clock),
        .reset          (reset),
        .refresh_timer  (refresh_timer),
        .dma_request    (dma_request),
        .dma_mask       (dma_mask),
        .chan           (chan)
    );

    generate
        for (genvar i = 0; i < num_channels; i++)
        begin : g_channel
            dreq_channel channel_inst
            (
                .clock  (clock),
                .reset  (reset),
                .chan   (chan[i])
            );
        end
    endgenerate

    dma_priority_arbiter arbiter_inst
    (
        .clock          (clock),
        .reset          (reset),
        .chan           (chan),
        .grant_valid    (grant_valid),
        .grant_channel  (grant_channel),
        .grant_ready    (grant_ready)
    );

    // Bus side expects active-low acknowledge lines
    generate
        for (genvar i = 0; i < num_channels; i++)
        begin : g_ack
            assign dma_acknowledge_n[i] = ~chan[i].acknowledge;
        end
    endgenerate

endmodule

/* hw/dreq_channel.sv */
module dreq_channel
(
    input  logic    clock,
    input  logic    reset,
    dreq_if.slot    chan
);

    logic request_latch;

    // Acknowledge has priority over a new set pulse
    always_ff @(posedge clock, posedge reset)
    begin
        if (reset)
        begin
            request_latch <= 1'b0;
        end
        else if (chan.acknowledge)
        begin
            request_latch <= 1'b0;
        end
        else if (chan.set)
        begin
            request_latch <= 1'b1;
        end
        else
        begin
            request_latch <= request_latch;
        end
    end

    // Masked requests stay latched and wait
    assign chan.pending = request_latch & ~chan.mask;

endmodule

/* hw/dreq_edge_detect.sv */
module dreq_edge_detect
(
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        refresh_timer,
    input  pcxt_dma_pkg::dma_ext_t      dma_request,
    input  pcxt_dma_pkg::dma_lines_t    dma_mask,
    dreq_if.source                      chan [pcxt_dma_pkg::num_channels]
);

    import pcxt_dma_pkg::*;

    logic       prev_refresh;
    dma_ext_t   prev_request;
    logic       refresh_rise;
    dma_ext_t   request_rise;

    // Previous samples start high so a line held through reset is ignored
    always_ff @(posedge clock, posedge reset)
    begin
        if (reset)
        begin
            prev_refresh <= 1'b1;
            prev_request <= '1;
        end
        else
        begin
            prev_refresh <= refresh_timer;
            prev_request <= dma_request;
        end
    end

    // High for the cycle where a line is high and was low before
    assign refresh_rise = refresh_timer & ~prev_refresh;
    assign request_rise = dma_request & ~prev_request;

    generate
        for (genvar i = 0; i < num_channels; i++)
        begin : g_route
            // External line index skips the refresh slot
            localparam int line = (i < refresh_channel) ? i : i - 1;

            if (i == refresh_channel)
            begin : g_refresh
                assign chan[i].set = refresh_rise;
            end
            else
            begin : g_external
                assign chan[i].set = request_rise[line];
            end

            assign chan[i].mask = dma_mask[i];
        end
    endgenerate

endmodule

/* hw/dreq_if.sv */
interface dreq_if;

    // Rising-edge pulse that latches the request
    logic set;

    // Hides the latched request from arbitration
    logic mask;

    // Latched and unmasked request
    logic pending;

    // One-cycle acknowledge after the grant is accepted
    logic acknowledge;

    modport source
    (
        output set,
        output mask
    );

    modport slot
    (
        input  set,
        input  mask,
        input  acknowledge,
        output pending
    );

    modport arbiter
    (
        input  pending,
        output acknowledge
    );

endinterface

/* hw/pcxt_dma_pkg.sv */
package pcxt_dma_pkg;

    // DMA channels handled by the request front end
    localparam int num_channels = 4;

    // Channel driven by the refresh timer, as on the XT board
    localparam int refresh_channel = 0;

    // Width of a channel number
    localparam int channel_width = $clog2(num_channels);

    // External request lines cover every channel except refresh
    localparam int ext_lines = num_channels - 1;

    // Channel number, as offered on the grant side
    typedef logic [channel_width-1:0] dma_channel_t;

    // One bit per channel
    // Used for masks and acknowledge lines
    typedef logic [num_channels-1:0] dma_lines_t;

    // Request lines from the expansion bus, channels 1 to 3
    typedef logic [ext_lines-1:0] dma_ext_t;

    // Arbiter states
    //   arb_idle  : waiting for an eligible request
    //   arb_offer : a channel is held on the grant side until accepted
    typedef enum logic
    {
        arb_idle,
        arb_offer
    } arb_state_t;

endpackage

/* tb/dma_request_unit_asserts.sv */
module dma_request_unit_asserts
(
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        grant_valid,
    input  pcxt_dma_pkg::dma_channel_t  grant_channel,
    input  logic                        grant_ready,
    input  pcxt_dma_pkg::dma_lines_t    acknowledge
);

    timeunit 1ns;
    timeprecision 100ps;

    // Offer stays put until the bus side takes it
    offer_held: assert property (@(posedge clock) disable iff (reset)
        grant_valid && !grant_ready |=> grant_valid && $stable(grant_channel))
        else $error("grant offer changed before it was accepted");

    ack_single_cycle: assert property (@(posedge clock) disable iff (reset)
        acknowledge != '0 |=> acknowledge == '0)
        else $error("acknowledge lasted longer than one cycle");

    // Only the accepted channel, one line, right after the transfer
    ack_after_transfer: assert property (@(posedge clock) disable iff (reset)
        acknowledge != '0 |-> $past(grant_valid && grant_ready)
            && $onehot(acknowledge) && acknowledge[$past(grant_channel)])
        else $error("acknowledge without a matching transfer");

endmodule

bind dma_priority_arbiter dma_request_unit_asserts asserts_inst
(
    .clock          (clock),
    .reset          (reset),
    .grant_valid    (grant_valid),
    .grant_channel  (grant_channel),
    .grant_ready    (grant_ready),
    .acknowledge    (ack_q)
);

/* tb/tb_dma_request_unit.sv */
module tb_dma_request_unit;

    timeunit 1ns;
    timeprecision 100ps;

    import pcxt_dma_pkg::*;

    localparam int clock_period = 40;
    localparam int reset_cycles = 4;
    localparam logic [15:0] lfsr_seed = 16'd13055;
    // x^16 + x^14 + x^13 + x^11 + 1
    localparam logic [15:0] lfsr_taps = 16'hB400;
    localparam int reset_len = 20;
    localparam int refresh_len = 40;
    localparam int priority_len = 60;
    localparam int mask_len = 60;
    localparam int random_len = 400;
    localparam int drain_len = 100;
    localparam int watchdog_time = (reset_cycles + reset_len + refresh_len + priority_len
        + mask_len + random_len + drain_len + 50) * clock_period;

    logic           clock;
    logic           reset;
    logic           refresh_timer;
    dma_ext_t       dma_request;
    dma_lines_t     dma_mask;
    logic           grant_valid;
    dma_channel_t   grant_channel;
    logic           grant_ready;
    dma_lines_t     dma_acknowledge_n;

    // Model of latched requests, in cycles of the counter below
    logic           req_valid [num_channels];
    int             req_cycle [num_channels];
    int             done_cycle [num_channels];
    int             edge_count [num_channels];
    int             grant_count [num_channels];
    dma_lines_t     line_state;
    dma_channel_t   grant_log [$];

    logic           offer_seen;
    dma_channel_t   offer_channel;
    logic           ack_due;
    dma_channel_t   ack_channel;
    dma_lines_t     last_mask;
    dma_lines_t     latched;

    int             cycle;
    int             errors;
    int             checks;
    int             tests;
    logic [15:0]    lfsr_state;

    dma_request_unit dma_request_unit_inst
    (
        .clock              (clock),
        .reset              (reset),
        .refresh_timer      (refresh_timer),
        .dma_request        (dma_request),
        .dma_mask           (dma_mask),
        .grant_valid        (grant_valid),
        .grant_channel      (grant_channel),
        .grant_ready        (grant_ready),
        .dma_acknowledge_n  (dma_acknowledge_n)
    );

    always #(clock_period / 2) clock = ~clock;

    always @(posedge clock) cycle <= cycle + 1;

    function automatic logic [7:0] take_bits(input int count);
        logic [7:0] value;
        value = '0;
        for (int i = 0; i < count; i++)
        begin
            lfsr_state = {lfsr_state[14:0], ^(lfsr_state & lfsr_taps)};
            value = {value[6:0], lfsr_state[0]};
        end
        return value;
    endfunction

    // Lowest channel that is latched and not masked
    function automatic dma_channel_t expected_channel(input dma_lines_t lines,
                                                      input dma_lines_t mask);
        dma_channel_t result;
        logic found;
        result = '0;
        found = 1'b0;
        for (int c = 0; c < num_channels; c++)
        begin
            if (lines[c] && !mask[c] && !found)
            begin
                result = dma_channel_t'(c);
                found = 1'b1;
            end
        end
        return result;
    endfunction

    // True when every open request is at least three cycles old
    function automatic logic edges_settled();
        for (int c = 0; c < num_channels; c++)
            if (req_valid[c] && req_cycle[c] + 3 > cycle)
                return 1'b0;
        return 1'b1;
    endfunction

    task automatic check_channel(input string name, input dma_channel_t expected,
                                 input dma_channel_t actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("Mismatch at %0d ns: %s expected %0d, actual %0d",
                     $time, name, expected, actual);
        end
    endtask

    task automatic check_lines(input string name, input dma_lines_t expected,
                               input dma_lines_t actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("Mismatch at %0d ns: %s expected %b, actual %b",
                     $time, name, expected, actual);
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("Mismatch at %0d ns: %s expected %b, actual %b",
                     $time, name, expected, actual);
        end
    endtask

    // Call right after a rising edge, then apply_lines
    task automatic raise_line(input int c);
        line_state[c] = 1'b1;
        req_valid[c] = 1'b1;
        req_cycle[c] = cycle;
        edge_count[c]++;
    endtask

    task automatic apply_lines();
        refresh_timer <= line_state[refresh_channel];
        dma_request <= dma_ext_t'(line_state >> 1);
    endtask

    task automatic wait_grants(input int count, input int max_cycles);
        int waited;
        waited = 0;
        while (grant_log.size() < count && waited < max_cycles)
        begin
            @(posedge clock);
            waited++;
        end
        if (grant_log.size() < count)
        begin
            errors++;
            $display("Error at %0d ns: waited for %0d grants but only %0d arrived",
                     $time, count, grant_log.size());
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests++;
        if (errors == errors_before)
            $display("Test %s: passed", name);
        else
            $display("Test %s: failed with %0d errors", name, errors - errors_before);
    endtask

    // Checks each offer, its stability, and the acknowledge after each transfer
    always @(negedge clock)
    begin
        if (!reset)
        begin
            latched = '0;
            for (int c = 0; c < num_channels; c++)
                if (req_valid[c] && req_cycle[c] + 3 <= cycle)
                    latched[c] = 1'b1;
            if (grant_valid && !offer_seen)
            begin
                if ((latched & ~last_mask) == '0)
                begin
                    errors++;
                    $display("Error at %0d ns: grant offered with no unmasked request", $time);
                end
                else
                    check_channel("grant_channel", expected_channel(latched, last_mask),
                                  grant_channel);
                offer_channel = grant_channel;
            end
            else if (grant_valid)
                check_channel("grant_channel", offer_channel, grant_channel);
            if (ack_due)
                check_lines("dma_acknowledge_n", ~(dma_lines_t'(1) << ack_channel),
                            dma_acknowledge_n);
            else
                check_lines("dma_acknowledge_n", '1, dma_acknowledge_n);
            ack_due = 1'b0;
            if (grant_valid && grant_ready)
            begin
                if (!req_valid[grant_channel])
                begin
                    errors++;
                    $display("Error at %0d ns: channel %0d granted without a request",
                             $time, grant_channel);
                end
                req_valid[grant_channel] = 1'b0;
                done_cycle[grant_channel] = cycle;
                grant_count[grant_channel]++;
                grant_log.push_back(grant_channel);
                ack_due = 1'b1;
                ack_channel = grant_channel;
            end
            offer_seen = grant_valid && !grant_ready;
            last_mask = dma_mask;
        end
    end

    initial
    begin
        #(watchdog_time);
        $display("Timeout: the tests did not finish within %0d ns", watchdog_time);
        $display("Errors found");
        $finish;
    end

    initial
    begin
        int first;
        int waited;
        logic [7:0] bits;
        logic open;

        clock = 1'b0;
        reset = 1'b1;
        refresh_timer = 1'b1;
        dma_request = '1;
        dma_mask = '0;
        grant_ready = 1'b0;
        line_state = '1;
        cycle = 0;
        errors = 0;
        checks = 0;
        tests = 0;
        lfsr_state = lfsr_seed;
        offer_seen = 1'b0;
        offer_channel = '0;
        ack_due = 1'b0;
        ack_channel = '0;
        last_mask = '0;
        for (int c = 0; c < num_channels; c++)
        begin
            req_valid[c] = 1'b0;
            req_cycle[c] = 0;
            done_cycle[c] = -1;
            edge_count[c] = 0;
            grant_count[c] = 0;
        end
        repeat (reset_cycles) @(posedge clock);
        reset <= 1'b0;

        // Lines held high through reset must stay silent
        first = errors;
        @(negedge clock);
        check_lines("dma_acknowledge_n", '1, dma_acknowledge_n);
        repeat (reset_len)
        begin
            @(negedge clock);
            check_bit("grant_valid", 1'b0, grant_valid);
        end
        @(posedge clock);
        line_state = '0;
        apply_lines();
        report_test("reset", first);

        first = errors;
        grant_log.delete();
        @(posedge clock);
        grant_ready <= 1'b1;
        raise_line(refresh_channel);
        apply_lines();
        wait_grants(1, 20);
        repeat (10) @(posedge clock);
        if (grant_log.size() != 1)
        begin
            errors++;
            $display("Error at %0d ns: refresh gave %0d grants instead of one",
                     $time, grant_log.size());
        end
        else
            check_channel("grant_channel", dma_channel_t'(refresh_channel), grant_log[0]);
        line_state = '0;
        apply_lines();
        report_test("refresh", first);

        first = errors;
        grant_log.delete();
        @(posedge clock);
        grant_ready <= 1'b0;
        for (int c = 0; c < num_channels; c++)
            raise_line(c);
        apply_lines();
        repeat (20) @(negedge clock);
        check_bit("grant_valid", 1'b1, grant_valid);
        @(posedge clock);
        grant_ready <= 1'b1;
        wait_grants(num_channels, 30);
        for (int c = 0; c < num_channels; c++)
            if (c < grant_log.size())
                check_channel("grant_channel", dma_channel_t'(c), grant_log[c]);
        @(posedge clock);
        line_state = '0;
        apply_lines();
        report_test("priority", first);

        first = errors;
        grant_log.delete();
        @(posedge clock);
        dma_mask <= dma_lines_t'(1) << 2;
        @(posedge clock);
        raise_line(2);
        apply_lines();
        repeat (30)
        begin
            @(negedge clock);
            check_bit("grant_valid", 1'b0, grant_valid);
        end
        @(posedge clock);
        dma_mask <= '0;
        wait_grants(1, 20);
        if (grant_log.size() > 0)
            check_channel("grant_channel", 2'd2, grant_log[0]);
        @(posedge clock);
        line_state = '0;
        apply_lines();
        report_test("mask", first);

        first = errors;
        repeat (random_len)
        begin
            @(posedge clock);
            for (int c = 0; c < num_channels; c++)
            begin
                bits = take_bits(3);
                if (line_state[c] && bits[1:0] == 2'b00)
                    line_state[c] = 1'b0;
                else if (!line_state[c] && !req_valid[c] && cycle > done_cycle[c]
                         && bits == 8'd7)
                    raise_line(c);
            end
            grant_ready <= (take_bits(2) != 8'd0);
            if (!grant_valid && edges_settled() && take_bits(4) == 8'd0)
                dma_mask <= dma_lines_t'(take_bits(4));
            apply_lines();
        end
        // Drain everything still latched
        @(posedge clock);
        line_state = '0;
        apply_lines();
        dma_mask <= '0;
        grant_ready <= 1'b1;
        waited = 0;
        open = 1'b1;
        while (open && waited < drain_len)
        begin
            @(negedge clock);
            waited++;
            open = grant_valid;
            for (int c = 0; c < num_channels; c++)
                open = open | req_valid[c];
        end
        // Let the last acknowledge check complete
        @(posedge clock);
        if (open)
        begin
            errors++;
            $display("Error at %0d ns: requests still open after the drain", $time);
        end
        for (int c = 0; c < num_channels; c++)
        begin
            checks++;
            if (grant_count[c] != edge_count[c])
            begin
                errors++;
                $display("Mismatch at %0d ns: grant_count[%0d] expected %0d, actual %0d",
                         $time, c, edge_count[c], grant_count[c]);
            end
        end
        report_test("random", first);

        $display("Tests run: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule
